// File: Makefile
TOP := int_alu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f verilog.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/int_alu_props.sv
`timescale 1ns/10ps

module int_alu_props import int_alu_pkg::*; #(
    parameter  int RESP_DEPTH = 4,
    localparam int CNT_W      = $clog2(RESP_DEPTH + 1)
) (
    input  logic               i_clk,
    input  logic               i_nrst,
    input  alu_resp_t          i_resp,
    input  logic               i_resp_valid,
    input  logic               i_resp_ready,
    input  logic [CNT_W-1:0]   i_fifo_count,
    input  logic               i_stage_valid
);

    // Nothing can be queued right out of reset
    resp_idle_after_reset: assert property (
        @(posedge i_clk) $rose(i_nrst) |-> !i_resp_valid
    ) else $error("response valid in the first cycle after reset");

    // Stalled response must not change under the consumer
    resp_stable_on_stall: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (i_resp_valid && !i_resp_ready) |=> $stable(i_resp)
    ) else $error("response changed while stalled");

    // Stage plus queue never hold more responses than the queue can take
    no_queue_overrun: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (int'(i_stage_valid) + int'(i_fifo_count)) <= RESP_DEPTH
    ) else $error("stage and queue hold more responses than the queue depth");

endmodule : int_alu_props

bind int_alu_top int_alu_props #(
    .RESP_DEPTH (RESP_DEPTH)
) props_i (
    .i_clk          (i_clk),
    .i_nrst         (i_nrst),
    .i_resp         (o_resp),
    .i_resp_valid   (o_resp_valid),
    .i_resp_ready   (i_resp_ready),
    .i_fifo_count   (fifo_count),
    .i_stage_valid  (wr_valid)
);

// File: bench/int_alu_tb.sv
`timescale 1ns/10ps

module int_alu_tb import riscv_cfg_pkg::*, int_alu_pkg::*; ();

    localparam int DEPTH     = 4;
    localparam int MAX_CYCLES = 4000;
    localparam logic [ARCH_W-1:0] CMP_VALS [4] = '{
        64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF,
        64'h0000_0000_0000_0000, 64'h0000_0000_8000_0000
    };
    localparam int SHIFTS [4] = '{0, 31, 32, 63};

    logic       clk;
    logic       nrst;
    alu_req_t   req;
    logic       req_valid;
    logic       req_ready;
    alu_resp_t  resp;
    logic       resp_valid;
    logic       resp_ready;

    alu_resp_t  exp_q [$];
    alu_resp_t  exp_resp;
    int         tag_ctr = 0;
    int         n_sent = 0;
    int         n_recv = 0;
    int         cycles = 0;

    int_alu_top #(
        .RESP_DEPTH (DEPTH)
    ) dut_i (
        .i_clk          (clk),
        .i_nrst         (nrst),
        .i_req          (req),
        .i_req_valid    (req_valid),
        .o_req_ready    (req_ready),
        .o_resp         (resp),
        .o_resp_valid   (resp_valid),
        .i_resp_ready   (resp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic compare(string name, logic [ARCH_W-1:0] got, logic [ARCH_W-1:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [ARCH_W-1:0] sext_word(logic [ARCH_W-1:0] v);
        return {{(ARCH_W - WORD_W){v[WORD_W-1]}}, v[WORD_W-1:0]};
    endfunction

    // Behavioural model of the integer rules
    function automatic logic [ARCH_W-1:0] model(alu_req_t r);
        logic [ARCH_W-1:0] a;
        logic [ARCH_W-1:0] b;
        logic [ARCH_W-1:0] res;
        logic              lt_s;
        logic              lt_u;
        int                sh;
        a    = r.word ? sext_word(r.a1) : r.a1;
        b    = r.word ? sext_word(r.a2) : r.a2;
        lt_s = $signed(a) < $signed(b);
        lt_u = a < b;
        sh   = r.word ? int'(r.a2[4:0]) : int'(r.a2[5:0]);
        case (r.op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_SLT:  res = ARCH_W'(lt_s);
            OP_SLTU: res = ARCH_W'(lt_u);
            OP_MIN:  res = lt_s ? a : b;
            OP_MINU: res = lt_u ? a : b;
            OP_MAX:  res = lt_s ? b : a;
            OP_MAXU: res = lt_u ? b : a;
            OP_AND:  res = r.a1 & r.a2;
            OP_OR:   res = r.a1 | r.a2;
            OP_XOR:  res = r.a1 ^ r.a2;
            OP_SLL:  res = r.a1 << sh;
            OP_SRL: begin
                if (r.word) begin
                    res = {{(ARCH_W - WORD_W){1'b0}}, r.a1[WORD_W-1:0]} >> sh;
                end else begin
                    res = r.a1 >> sh;
                end
            end
            OP_SRA: begin
                if (r.word) begin
                    res = $signed(sext_word(r.a1)) >>> sh;
                end else begin
                    res = $signed(r.a1) >>> sh;
                end
            end
            default: res = '0;
        endcase
        return r.word ? sext_word(res) : res;
    endfunction

    // Monitor counts request handshakes and pops the expected queue on every response
    always @(posedge clk) begin
        if (nrst && req_valid && req_ready) begin
            n_sent = n_sent + 1;
        end
        if (nrst && resp_valid && resp_ready) begin
            if (exp_q.size() == 0) begin
                $display("Response with tag %0d arrived with no request outstanding", resp.tag);
                $display("CHECKS FAILED");
                $fatal(1, "unexpected response");
            end else begin
                exp_resp = exp_q.pop_front();
                compare("o_resp.tag", ARCH_W'(resp.tag), ARCH_W'(exp_resp.tag));
                compare("o_resp.result", resp.result, exp_resp.result);
                n_recv = n_recv + 1;
            end
        end
    end

    function automatic alu_req_t make_req(alu_op_e op, logic word, logic [ARCH_W-1:0] a1,
                                          logic [ARCH_W-1:0] a2);
        alu_req_t r;
        r.op   = op;
        r.word = word;
        r.a1   = a1;
        r.a2   = a2;
        r.tag  = TAG_W'(tag_ctr);
        return r;
    endfunction

    task automatic record_accept();
        exp_q.push_back('{result: model(req), tag: req.tag});
        tag_ctr = tag_ctr + 1;
    endtask

    // Present one request and hold it until a credit is free
    task automatic issue(alu_op_e op, logic word, logic [ARCH_W-1:0] a1, logic [ARCH_W-1:0] a2);
        @(negedge clk);
        req       = make_req(op, word, a1, a2);
        req_valid = 1'b1;
        while (!req_ready) begin
            @(negedge clk);
        end
        record_accept();
    endtask

    task automatic idle();
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic drain();
        idle();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic reset_test();
        @(negedge clk);
        compare("o_resp_valid", ARCH_W'(resp_valid), '0);
        compare("o_req_ready", ARCH_W'(req_ready), ARCH_W'(1));
    endtask

    task automatic add_sub_test();
        issue(OP_ADD, 1'b0, 64'hFFFF_FFFF_FFFF_FFFF, 64'd1);
        issue(OP_SUB, 1'b0, 64'd0, 64'd1);
        issue(OP_ADD, 1'b0, 64'h1234_5678_9ABC_DEF0, 64'h0FED_CBA9_8765_4321);
        issue(OP_ADD, 1'b1, 64'h0000_0000_7FFF_FFFF, 64'd1);
        issue(OP_SUB, 1'b1, 64'h1111_1111_0000_0000, 64'd1);
        issue(OP_ADD, 1'b1, 64'hABCD_0000_8000_0000, 64'h0);
        issue(OP_SUB, 1'b1, 64'h0000_0000_8000_0000, 64'hFFFF_FFFF_0000_0001);
        drain();
    endtask

    task automatic compare_ops_test();
        for (int k = int'(OP_SLT); k <= int'(OP_MAXU); k++) begin
            for (int w = 0; w < 2; w++) begin
                for (int i = 0; i < 4; i++) begin
                    for (int j = 0; j < 4; j++) begin
                        issue(alu_op_e'(k), 1'(w), CMP_VALS[i], CMP_VALS[j]);
                    end
                end
            end
        end
        drain();
    endtask

    task automatic logic_shift_test();
        for (int w = 0; w < 2; w++) begin
            issue(OP_AND, 1'(w), 64'hF0F0_1234_8765_FFFF, 64'h0FF0_FFFF_F0F0_0001);
            issue(OP_OR, 1'(w), 64'hF0F0_1234_0765_FFFF, 64'h0FF0_0000_F0F0_0001);
            issue(OP_XOR, 1'(w), 64'hF0F0_1234_8765_FFFF, 64'hFFFF_0000_0F0F_0000);
            for (int s = 0; s < 4; s++) begin
                // Upper amount bits set to confirm masking in word mode
                issue(OP_SLL, 1'(w), 64'h8000_0001_8000_00F1, 64'hFC0 | ARCH_W'(SHIFTS[s]));
                issue(OP_SRL, 1'(w), 64'h8000_0001_8000_00F1, ARCH_W'(SHIFTS[s]));
                issue(OP_SRA, 1'(w), 64'h8000_0001_8000_00F1, ARCH_W'(SHIFTS[s]));
            end
        end
        drain();
    endtask

    task automatic back_pressure_test();
        int accepted;
        accepted   = 0;
        resp_ready = 1'b0;
        for (int i = 0; i < 2 * DEPTH; i++) begin
            @(negedge clk);
            req       = make_req(OP_ADD, 1'b0, ARCH_W'(i), 64'h100);
            req_valid = 1'b1;
            if (req_ready) begin
                record_accept();
                accepted = accepted + 1;
            end
        end
        idle();
        compare("accepted requests", ARCH_W'(accepted), ARCH_W'(DEPTH));
        compare("o_req_ready", ARCH_W'(req_ready), '0);
        resp_ready = 1'b1;
        drain();
    endtask

    task automatic random_test(int n);
        logic done;
        done = 1'b0;
        fork
            begin
                for (int i = 0; i < n; i++) begin
                    if ($urandom_range(3) == 0) begin
                        idle();
                    end
                    issue(alu_op_e'($urandom_range(13)), 1'($urandom_range(1)),
                          {$urandom, $urandom}, {$urandom, $urandom});
                end
                idle();
                done = 1'b1;
            end
            begin
                while (!done) begin
                    @(negedge clk);
                    resp_ready = 1'($urandom_range(1));
                end
            end
        join
        resp_ready = 1'b1;
        drain();
    endtask

    initial begin
        void'($urandom(98));
        nrst       = 1'b0;
        req        = '0;
        req_valid  = 1'b0;
        resp_ready = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
        reset_test();
        add_sub_test();
        compare_ops_test();
        logic_shift_test();
        back_pressure_test();
        random_test(500);
        // Quiet window so a stray or duplicated response would show up
        repeat (DEPTH + 2) @(negedge clk);
        compare("o_resp_valid", ARCH_W'(resp_valid), '0);
        compare("response count", ARCH_W'(n_recv), ARCH_W'(n_sent));
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule : int_alu_tb

// File: src/alu_issue.sv
`timescale 1ns/10ps

module alu_issue import riscv_cfg_pkg::*, int_alu_pkg::*; #(
    parameter  int RESP_DEPTH = 4,
    localparam int CNT_W      = $clog2(RESP_DEPTH + 1)
) (
    input  logic                i_clk,
    input  logic                i_nrst,
    input  alu_req_t            i_req,
    input  logic                i_req_valid,
    output logic                o_req_ready,
    output addsub_mode_t        o_addsub_mode,
    output lsh_mode_t           o_lsh_mode,
    output logic [ARCH_W-1:0]   o_a1,
    output logic [ARCH_W-1:0]   o_a2,
    input  logic [ARCH_W-1:0]   i_addsub_res,
    input  logic [ARCH_W-1:0]   i_lsh_res,
    input  logic [CNT_W-1:0]    i_fifo_count,
    output logic                o_wr_valid,
    output alu_resp_t           o_wr_data
);

    logic               accept;
    logic               sel_lsh;
    logic [CNT_W:0]     in_flight;
    logic               st_valid;
    logic               st_lsh;
    logic [TAG_W-1:0]   st_tag;

    // Opcode decode into the two unit modes
    always_comb begin
        o_addsub_mode.kind = AS_ADD;
        o_addsub_mode.uns  = 1'b0;
        o_addsub_mode.word = i_req.word;
        o_lsh_mode.kind    = LS_AND;
        o_lsh_mode.word    = i_req.word;
        sel_lsh            = 1'b0;
        case (i_req.op)
            OP_ADD:  o_addsub_mode.kind = AS_ADD;
            OP_SUB:  o_addsub_mode.kind = AS_SUB;
            OP_SLT:  o_addsub_mode.kind = AS_LESS;
            OP_SLTU: begin
                o_addsub_mode.kind = AS_LESS;
                o_addsub_mode.uns  = 1'b1;
            end
            OP_MIN:  o_addsub_mode.kind = AS_MIN;
            OP_MINU: begin
                o_addsub_mode.kind = AS_MIN;
                o_addsub_mode.uns  = 1'b1;
            end
            OP_MAX:  o_addsub_mode.kind = AS_MAX;
            OP_MAXU: begin
                o_addsub_mode.kind = AS_MAX;
                o_addsub_mode.uns  = 1'b1;
            end
            OP_AND: begin
                o_lsh_mode.kind = LS_AND;
                sel_lsh         = 1'b1;
            end
            OP_OR: begin
                o_lsh_mode.kind = LS_OR;
                sel_lsh         = 1'b1;
            end
            OP_XOR: begin
                o_lsh_mode.kind = LS_XOR;
                sel_lsh         = 1'b1;
            end
            OP_SLL: begin
                o_lsh_mode.kind = LS_SLL;
                sel_lsh         = 1'b1;
            end
            OP_SRL: begin
                o_lsh_mode.kind = LS_SRL;
                sel_lsh         = 1'b1;
            end
            OP_SRA: begin
                o_lsh_mode.kind = LS_SRA;
                sel_lsh         = 1'b1;
            end
            default: sel_lsh = 1'b0;
        endcase
    end

    // Both units see the same operands
    assign o_a1 = i_req.a1;
    assign o_a2 = i_req.a2;

    // Credits cover the stage slot and every queued response
    assign in_flight   = {{CNT_W{1'b0}}, st_valid} + {1'b0, i_fifo_count};
    assign o_req_ready = (in_flight < (CNT_W + 1)'(RESP_DEPTH));
    assign accept      = i_req_valid && o_req_ready;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            st_valid <= 1'b0;
        end else begin
            st_valid <= accept;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            st_lsh <= sel_lsh;
            st_tag <= i_req.tag;
        end
    end

    // Unit results are registered, so they line up with the stage
    assign o_wr_valid       = st_valid;
    assign o_wr_data.result = st_lsh ? i_lsh_res : i_addsub_res;
    assign o_wr_data.tag    = st_tag;

endmodule : alu_issue

// File: src/alu_resp_fifo.sv
`timescale 1ns/10ps

module alu_resp_fifo import int_alu_pkg::*; #(
    parameter  int RESP_DEPTH = 4,
    localparam int CNT_W      = $clog2(RESP_DEPTH + 1),
    localparam int PTR_W      = $clog2(RESP_DEPTH)
) (
    input  logic               i_clk,
    input  logic               i_nrst,
    input  logic               i_wr_valid,
    input  alu_resp_t          i_wr_data,
    output alu_resp_t          o_resp,
    output logic               o_resp_valid,
    input  logic               i_resp_ready,
    output logic [CNT_W-1:0]   o_count
);

    alu_resp_t          mem [RESP_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               rd_en;

    // Overflow is prevented upstream by the credit check
    assign rd_en = o_resp_valid && i_resp_ready;

    always_ff @(posedge i_clk) begin
        if (i_wr_valid) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_wr_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(RESP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(RESP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous write and read leaves the count unchanged
            if (i_wr_valid && !rd_en) begin
                count <= count + 1'b1;
            end else if (!i_wr_valid && rd_en) begin
                count <= count - 1'b1;
            end
        end
    end

    assign o_resp       = mem[rd_ptr];
    assign o_resp_valid = (count != '0);
    assign o_count      = count;

endmodule : alu_resp_fifo

// File: src/int_addsub.sv
`timescale 1ns/10ps

module int_addsub import riscv_cfg_pkg::*, int_alu_pkg::*; (
    input  logic                i_clk,
    input  logic                i_nrst,
    input  addsub_mode_t        i_mode,
    input  logic [ARCH_W-1:0]   i_a1,
    input  logic [ARCH_W-1:0]   i_a2,
    output logic [ARCH_W-1:0]   o_res
);

    logic [ARCH_W-1:0] op1;
    logic [ARCH_W-1:0] op2;
    logic [ARCH_W-1:0] sum;
    logic [ARCH_W-1:0] diff;
    logic              less_u;
    logic              less_s;
    logic              less;
    logic [ARCH_W-1:0] res_raw;
    logic [ARCH_W-1:0] res_next;
    logic [ARCH_W-1:0] res_q;

    // Word mode works on sign-extended low halves
    always_comb begin
        if (i_mode.word) begin
            op1 = {{(ARCH_W - WORD_W){i_a1[WORD_W-1]}}, i_a1[WORD_W-1:0]};
            op2 = {{(ARCH_W - WORD_W){i_a2[WORD_W-1]}}, i_a2[WORD_W-1:0]};
        end else begin
            op1 = i_a1;
            op2 = i_a2;
        end
    end

    assign sum  = op1 + op2;
    assign diff = op1 - op2;

    assign less_u = (op1 < op2);
    // Sign of the difference is only trusted when operand signs agree,
    // otherwise the negative operand is the smaller one
    assign less_s = (op1[ARCH_W-1] != op2[ARCH_W-1]) ? op1[ARCH_W-1] : diff[ARCH_W-1];
    assign less   = i_mode.uns ? less_u : less_s;

    always_comb begin
        res_raw = '0;
        case (i_mode.kind)
            AS_ADD:  res_raw = sum;
            AS_SUB:  res_raw = diff;
            AS_LESS: res_raw[0] = less;
            AS_MIN:  res_raw = less ? op1 : op2;
            AS_MAX:  res_raw = less ? op2 : op1;
            default: res_raw = '0;
        endcase
    end

    // W forms return a sign-extended 32-bit result
    always_comb begin
        if (i_mode.word) begin
            res_next = {{(ARCH_W - WORD_W){res_raw[WORD_W-1]}}, res_raw[WORD_W-1:0]};
        end else begin
            res_next = res_raw;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            res_q <= '0;
        end else begin
            res_q <= res_next;
        end
    end

    assign o_res = res_q;

endmodule : int_addsub

// File: src/int_alu_pkg.sv
package int_alu_pkg;

    import riscv_cfg_pkg::*;

    localparam int TAG_W = 4;

    // Request opcodes seen at the ALU port
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_SLTU,
        OP_MIN,
        OP_MINU,
        OP_MAX,
        OP_MAXU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA
    } alu_op_e;

    // Add/sub/compare unit operations
    typedef enum logic [2:0] {
        AS_ADD,
        AS_SUB,
        AS_LESS,
        AS_MIN,
        AS_MAX
    } addsub_kind_e;

    // Logic/shift unit operations
    typedef enum logic [2:0] {
        LS_AND,
        LS_OR,
        LS_XOR,
        LS_SLL,
        LS_SRL,
        LS_SRA
    } lsh_kind_e;

    typedef struct packed {
        alu_op_e            op;
        logic               word;
        logic [ARCH_W-1:0]  a1;
        logic [ARCH_W-1:0]  a2;
        logic [TAG_W-1:0]   tag;
    } alu_req_t;

    typedef struct packed {
        logic [ARCH_W-1:0]  result;
        logic [TAG_W-1:0]   tag;
    } alu_resp_t;

    typedef struct packed {
        addsub_kind_e       kind;
        logic               uns;
        logic               word;
    } addsub_mode_t;

    typedef struct packed {
        lsh_kind_e          kind;
        logic               word;
    } lsh_mode_t;

endpackage : int_alu_pkg

// File: src/int_alu_top.sv
`timescale 1ns/10ps

module int_alu_top import riscv_cfg_pkg::*, int_alu_pkg::*; #(
    parameter  int RESP_DEPTH = 4,
    localparam int CNT_W      = $clog2(RESP_DEPTH + 1)
) (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  alu_req_t    i_req,
    input  logic        i_req_valid,
    output logic        o_req_ready,
    output alu_resp_t   o_resp,
    output logic        o_resp_valid,
    input  logic        i_resp_ready
);

    addsub_mode_t       addsub_mode;
    lsh_mode_t          lsh_mode;
    logic [ARCH_W-1:0]  a1;
    logic [ARCH_W-1:0]  a2;
    logic [ARCH_W-1:0]  addsub_res;
    logic [ARCH_W-1:0]  lsh_res;
    logic [CNT_W-1:0]   fifo_count;
    logic               wr_valid;
    alu_resp_t          wr_data;

    alu_issue #(
        .RESP_DEPTH (RESP_DEPTH)
    ) issue_i (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_req          (i_req),
        .i_req_valid    (i_req_valid),
        .o_req_ready    (o_req_ready),
        .o_addsub_mode  (addsub_mode),
        .o_lsh_mode     (lsh_mode),
        .o_a1           (a1),
        .o_a2           (a2),
        .i_addsub_res   (addsub_res),
        .i_lsh_res      (lsh_res),
        .i_fifo_count   (fifo_count),
        .o_wr_valid     (wr_valid),
        .o_wr_data      (wr_data)
    );

    int_addsub addsub_i (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_mode (addsub_mode),
        .i_a1   (a1),
        .i_a2   (a2),
        .o_res  (addsub_res)
    );

    int_logic_shift lsh_i (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_mode (lsh_mode),
        .i_a1   (a1),
        .i_a2   (a2),
        .o_res  (lsh_res)
    );

    alu_resp_fifo #(
        .RESP_DEPTH (RESP_DEPTH)
    ) fifo_i (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_wr_valid     (wr_valid),
        .i_wr_data      (wr_data),
        .o_resp         (o_resp),
        .o_resp_valid   (o_resp_valid),
        .i_resp_ready   (i_resp_ready),
        .o_count        (fifo_count)
    );

endmodule : int_alu_top

// File: src/int_logic_shift.sv
`timescale 1ns/10ps

module int_logic_shift import riscv_cfg_pkg::*, int_alu_pkg::*; (
    input  logic                i_clk,
    input  logic                i_nrst,
    input  lsh_mode_t           i_mode,
    input  logic [ARCH_W-1:0]   i_a1,
    input  logic [ARCH_W-1:0]   i_a2,
    output logic [ARCH_W-1:0]   o_res
);

    logic [5:0]        shamt;
    logic [ARCH_W-1:0] lo_zext;
    logic [ARCH_W-1:0] lo_sext;
    logic [ARCH_W-1:0] res_raw;
    logic [ARCH_W-1:0] res_next;
    logic [ARCH_W-1:0] res_q;

    // Shift amount is masked to 5 bits for W forms
    assign shamt = i_mode.word ? {1'b0, i_a2[4:0]} : i_a2[5:0];

    // Low word of a1 prepared for the W right shifts
    assign lo_zext = {{(ARCH_W - WORD_W){1'b0}}, i_a1[WORD_W-1:0]};
    assign lo_sext = {{(ARCH_W - WORD_W){i_a1[WORD_W-1]}}, i_a1[WORD_W-1:0]};

    always_comb begin
        res_raw = '0;
        case (i_mode.kind)
            LS_AND:  res_raw = i_a1 & i_a2;
            LS_OR:   res_raw = i_a1 | i_a2;
            LS_XOR:  res_raw = i_a1 ^ i_a2;
            LS_SLL:  res_raw = i_a1 << shamt;
            LS_SRL: begin
                if (i_mode.word) begin
                    res_raw = lo_zext >> shamt;
                end else begin
                    res_raw = i_a1 >> shamt;
                end
            end
            LS_SRA: begin
                if (i_mode.word) begin
                    res_raw = $signed(lo_sext) >>> shamt;
                end else begin
                    res_raw = $signed(i_a1) >>> shamt;
                end
            end
            default: res_raw = '0;
        endcase
    end

    always_comb begin
        if (i_mode.word) begin
            res_next = {{(ARCH_W - WORD_W){res_raw[WORD_W-1]}}, res_raw[WORD_W-1:0]};
        end else begin
            res_next = res_raw;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            res_q <= '0;
        end else begin
            res_q <= res_next;
        end
    end

    assign o_res = res_q;

endmodule : int_logic_shift

// File: src/riscv_cfg_pkg.sv
package riscv_cfg_pkg;

    // Datapath width of the RV64 core
    localparam int ARCH_W = 64;

    // Width of the W-suffixed instruction forms
    // Their results sign-extend from the top bit of this width
    localparam int WORD_W = 32;

endpackage : riscv_cfg_pkg

// File: verilog.f
src/riscv_cfg_pkg.sv
src/int_alu_pkg.sv
src/int_addsub.sv
src/int_logic_shift.sv
src/alu_issue.sv
src/alu_resp_fifo.sv
src/int_alu_top.sv
bench/int_alu_props.sv
bench/int_alu_tb.sv
